//--- Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Isrc --top-module manycore_profiler_top \
		src/prof_pkg.sv src/tile_profiler.sv src/prof_report_seq.sv \
		src/manycore_profiler_top.sv

obj_dir/tb_sim: tb.f src/prof_defs.svh src/*.sv sim/tb_manycore_profiler.sv
	verilator --binary --timing --assert --top-module tb_manycore_profiler \
		-f tb.f -o tb_sim

sim: obj_dir/tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tb_manycore_profiler.sv
`timescale 1ns/1ps
`include "prof_defs.svh"

module tb_manycore_profiler;

   localparam int RUN_CYCLES    = 4400;   // long enough to saturate tile 1
   localparam int START_TIMEOUT = 10;
   localparam int DONE_TIMEOUT  = 64;

   logic                                          clk;
   logic                                          rst_i;
   logic [`PROF_NUM_TILES-1:0]                    freeze_i;
   prof_pkg::prof_trigger_s [`PROF_NUM_TILES-1:0] trig_i;
   logic                                          finish_i;
   prof_pkg::report_s                             report_o;
   logic                                          report_v_o;
   logic                                          report_done_o;

   logic [31:0] lfsr;
   int          mismatch_cnt = 0;
   int          proto_cnt    = 0;
   int          timeout_cnt  = 0;

   // count model
   logic [`PROF_NUM_TILES-1:0] m_freeze_r;
   logic [`PROF_NUM_TILES-1:0] m_armed;
   logic                       m_done;
   prof_pkg::cnt_t             m_cnt [`PROF_NUM_TILES][`PROF_NUM_SLOTS];

   logic [5:0]          rec_cnt;   // records seen so far
   prof_pkg::tile_idx_t exp_tile;
   prof_pkg::slot_idx_t exp_slot;
   prof_pkg::cnt_t      exp_count;

   manycore_profiler_top uut (
      .clk           (clk),
      .rst_i         (rst_i),
      .freeze_i      (freeze_i),
      .trig_i        (trig_i),
      .finish_i      (finish_i),
      .report_o      (report_o),
      .report_v_o    (report_v_o),
      .report_done_o (report_done_o)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // slot number to event field
   function automatic logic slot_event(input prof_pkg::prof_trigger_s tr, input int s);
      case (s)
         0:       return tr.dmem_stall;
         1:       return tr.dx_stall;
         2:       return tr.bt_stall;
         3:       return tr.in_fifo_full;
         4:       return tr.out_fifo_full;
         5:       return tr.credit_full;
         default: return tr.res_acq_stall;
      endcase
   endfunction

   function automatic prof_pkg::cnt_t sat_inc(input prof_pkg::cnt_t c);
      if (c == {`PROF_CNT_WIDTH{1'b1}}) begin
         return c;   // stuck at all ones
      end
      return c + 1'b1;
   endfunction

   task automatic drive_triggers();
      logic [`PROF_NUM_EVENTS-1:0] bits;
      for (int t = 0; t < `PROF_NUM_TILES; t++) begin
         for (int b = 0; b < `PROF_NUM_EVENTS; b++) begin
            lfsr    = lfsr_step(lfsr);
            bits[b] = lfsr[0];
         end
         trig_i[t] = prof_pkg::prof_trigger_s'(bits);
      end
      trig_i[1].dmem_stall = 1'b1;   // pinned high on tile 1
   endtask

   // fresh triggers on each falling edge
   task automatic next_cycle();
      @(negedge clk);
      drive_triggers();
   endtask

   //////////////////////////////////////////////////
   // reference count model
   //////////////////////////////////////////////////

   always @(posedge clk) begin
      if (rst_i) begin
         m_freeze_r <= '0;
         m_armed    <= '0;
         m_done     <= 1'b0;
         for (int t = 0; t < `PROF_NUM_TILES; t++) begin
            for (int s = 0; s < `PROF_NUM_SLOTS; s++) begin
               m_cnt[t][s] <= '0;
            end
         end
      end else begin
         for (int t = 0; t < `PROF_NUM_TILES; t++) begin
            if (m_freeze_r[t] && !freeze_i[t]) begin   // unfreeze cycle is not counted
               m_armed[t] <= 1'b1;
               if (!m_done) begin
                  for (int s = 0; s < `PROF_NUM_SLOTS; s++) begin
                     m_cnt[t][s] <= '0;
                  end
               end
            end else if (m_armed[t] && !freeze_i[t] && !m_done) begin
               for (int s = 0; s < `PROF_NUM_EVENTS; s++) begin
                  if (slot_event(trig_i[t], s)) begin
                     m_cnt[t][s] <= sat_inc(m_cnt[t][s]);
                  end
               end
               m_cnt[t][`PROF_NUM_EVENTS] <= sat_inc(m_cnt[t][`PROF_NUM_EVENTS]);
            end
         end
         m_freeze_r <= freeze_i;
         if (finish_i) begin
            m_done <= 1'b1;   // finish cycle already counted above
         end
      end
   end

   always @(posedge clk) begin
      if (rst_i) begin
         rec_cnt <= '0;
      end else if (report_v_o) begin
         rec_cnt <= rec_cnt + 1'b1;
      end
   end

   // tile major walk
   assign exp_tile = rec_cnt[4:3];
   assign exp_slot = rec_cnt[2:0];

   always_comb begin
      exp_count = m_cnt[exp_tile][exp_slot];
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   a_quiet_before_finish: assert property (
      @(posedge clk) disable iff (rst_i)
      !m_done |-> (!report_v_o && !report_done_o)
   ) else begin
      proto_cnt++;
      $display("%0t: report port active before any finish pulse", $time);
   end

   a_stream_unbroken: assert property (
      @(posedge clk) disable iff (rst_i)
      (m_done && (rec_cnt < 6'd32)) |-> (report_v_o && !report_done_o)
   ) else begin
      proto_cnt++;
      $display("%0t: report stream broken or done raised early at record %0d",
               $time, $sampled(rec_cnt));
   end

   a_no_extra_record: assert property (
      @(posedge clk) disable iff (rst_i)
      report_v_o |-> (rec_cnt < 6'd32)
   ) else begin
      proto_cnt++;
      $display("%0t: report record beyond the expected 32", $time);
   end

   a_done_after_last: assert property (
      @(posedge clk) disable iff (rst_i)
      (rec_cnt == 6'd32) |-> (!report_v_o && report_done_o)
   ) else begin
      proto_cnt++;
      $display("%0t: report_done_o not held high after the last record", $time);
   end

   a_tile_index: assert property (
      @(posedge clk) disable iff (rst_i)
      report_v_o |-> (report_o.tile == exp_tile)
   ) else begin
      mismatch_cnt++;
      $display("MISMATCH %0t report_o.tile expected %0d got %0d",
               $time, $sampled(exp_tile), $sampled(report_o.tile));
   end

   a_slot_index: assert property (
      @(posedge clk) disable iff (rst_i)
      report_v_o |-> (report_o.slot == exp_slot)
   ) else begin
      mismatch_cnt++;
      $display("MISMATCH %0t report_o.slot expected %0d got %0d",
               $time, $sampled(exp_slot), $sampled(report_o.slot));
   end

   a_count_value: assert property (
      @(posedge clk) disable iff (rst_i)
      report_v_o |-> (report_o.count == exp_count)
   ) else begin
      mismatch_cnt++;
      $display("MISMATCH %0t report_o.count (tile %0d slot %0d) expected %0d got %0d",
               $time, $sampled(exp_tile), $sampled(exp_slot), $sampled(exp_count),
               $sampled(report_o.count));
   end

   // tile 3 never armed
   a_tile3_zero: assert property (
      @(posedge clk) disable iff (rst_i)
      (report_v_o && (report_o.tile == 2'd3)) |-> (report_o.count == '0)
   ) else begin
      mismatch_cnt++;
      $display("MISMATCH %0t report_o.count (tile 3) expected 0 got %0d",
               $time, $sampled(report_o.count));
   end

   a_tile1_saturated: assert property (
      @(posedge clk) disable iff (rst_i)
      (report_v_o && (report_o.tile == 2'd1) && (report_o.slot == 3'd0)) |->
         (report_o.count == {`PROF_CNT_WIDTH{1'b1}})
   ) else begin
      mismatch_cnt++;
      $display("MISMATCH %0t report_o.count (tile 1 dmem) expected %0d got %0d",
               $time, {`PROF_CNT_WIDTH{1'b1}}, $sampled(report_o.count));
   end

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   initial begin
      int to;
      rst_i    = 1'b1;
      freeze_i = 4'b0111;   // tile 3 never frozen
      trig_i   = '0;
      finish_i = 1'b0;
      lfsr     = 32'h7db39d20;

      repeat (10) @(negedge clk);
      rst_i = 1'b0;

      for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
         next_cycle();
         case (cyc)
            5:       freeze_i[1] = 1'b0;
            10:      freeze_i[2] = 1'b0;
            1000:    freeze_i[0] = 1'b0;
            2500:    freeze_i[2] = 1'b1;   // re-freeze tile 2
            2540:    freeze_i[2] = 1'b0;   // and clear it again
            default: ;
         endcase
      end

      next_cycle();
      finish_i = 1'b1;
      next_cycle();
      finish_i = 1'b0;

      to = 0;
      while (!report_v_o && (to < START_TIMEOUT)) begin
         next_cycle();
         to++;
      end
      if (!report_v_o) begin
         timeout_cnt++;
         $display("%0t: timeout waiting for the report stream to start", $time);
      end

      // second finish and freeze traffic while dumping
      next_cycle();
      finish_i    = 1'b1;
      freeze_i[0] = 1'b1;
      freeze_i[2] = 1'b1;
      next_cycle();
      finish_i    = 1'b0;
      freeze_i[0] = 1'b0;
      freeze_i[2] = 1'b0;

      to = 0;
      while (!report_done_o && (to < DONE_TIMEOUT)) begin
         next_cycle();
         to++;
      end
      if (!report_done_o) begin
         timeout_cnt++;
         $display("%0t: timeout waiting for report_done_o", $time);
      end

      // finish again once done
      next_cycle();
      finish_i = 1'b1;
      next_cycle();
      finish_i = 1'b0;
      repeat (20) next_cycle();

      a_record_total: assert (rec_cnt == 6'd32) else begin
         mismatch_cnt++;
         $display("MISMATCH %0t rec_cnt expected 32 got %0d", $time, rec_cnt);
      end

      $display("errors: %0d mismatch, %0d protocol, %0d timeout; records seen %0d",
               mismatch_cnt, proto_cnt, timeout_cnt, rec_cnt);
      if ((mismatch_cnt + proto_cnt + timeout_cnt) == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- src/manycore_profiler_top.sv
`timescale 1ns/1ps
`include "prof_defs.svh"

module manycore_profiler_top (
   input  logic                                           clk,
   input  logic                                           rst_i,
   input  logic [`PROF_NUM_TILES-1:0]                     freeze_i,
   input  prof_pkg::prof_trigger_s [`PROF_NUM_TILES-1:0] trig_i,
   input  logic                                           finish_i,
   output prof_pkg::report_s                              report_o,
   output logic                                           report_v_o,
   output logic                                           report_done_o
);

   prof_pkg::tile_counts_s [`PROF_NUM_TILES-1:0] counts_w;   // one bank per tile
   logic                                         done_w;     // global stop

   //////////////////////////////////////////////////
   // per tile profilers
   //////////////////////////////////////////////////

   for (genvar t = 0; t < `PROF_NUM_TILES; t++) begin : g_tile
      tile_profiler u_prof (
         .clk      (clk),
         .rst_i    (rst_i),
         .freeze_i (freeze_i[t]),
         .trig_i   (trig_i[t]),
         .done_i   (done_w),
         .counts_o (counts_w[t])
      );
   end

   //////////////////////////////////////////////////
   // finish handling and report stream
   //////////////////////////////////////////////////

   // shared by all tiles and streams one record per cycle after finish
   prof_report_seq u_seq (
      .clk           (clk),
      .rst_i         (rst_i),
      .finish_i      (finish_i),
      .counts_i      (counts_w),
      .done_o        (done_w),
      .report_o      (report_o),
      .report_v_o    (report_v_o),
      .report_done_o (report_done_o)
   );

endmodule

//--- src/prof_defs.svh
`ifndef PROF_DEFS_SVH
`define PROF_DEFS_SVH

//////////////////////////////////////////////////
// array and counter sizing
//////////////////////////////////////////////////

// tile count that also sizes the top level packed arrays
`define PROF_NUM_TILES 4

// stall event strobes per tile
`define PROF_NUM_EVENTS 7

// counter slots per tile are the events plus the cycle counter
`define PROF_NUM_SLOTS 8

// small enough that saturation shows up in simulation
`define PROF_CNT_WIDTH 12

`endif

//--- src/prof_pkg.sv
`include "prof_defs.svh"

package prof_pkg;

   //////////////////////////////////////////////////
   // widths with a meaning
   //////////////////////////////////////////////////

   typedef logic [`PROF_CNT_WIDTH-1:0] cnt_t;   // one counter value
   typedef logic [1:0]                 tile_idx_t;
   typedef logic [2:0]                 slot_idx_t;   // slot 7 counts cycles

   //////////////////////////////////////////////////
   // per tile event strobes
   //////////////////////////////////////////////////

   // field order is the slot order of the counters
   typedef struct packed {
      logic dmem_stall;      // data memory stall
      logic dx_stall;        // dependency stall
      logic bt_stall;        // branch flush
      logic in_fifo_full;
      logic out_fifo_full;
      logic credit_full;     // no credits left
      logic res_acq_stall;   // resource acquire
   } prof_trigger_s;

   // all counters of one tile by slot
   typedef struct packed {
      cnt_t [`PROF_NUM_SLOTS-1:0] cnt;
   } tile_counts_s;

   // one 17 bit record of the report stream
   typedef struct packed {
      tile_idx_t tile;
      slot_idx_t slot;
      cnt_t      count;
   } report_s;

   // report sequencer FSM
   typedef enum logic [1:0] {
      IDLE,
      DUMP,
      DONE
   } seq_state_e;

endpackage

//--- src/prof_report_seq.sv
`timescale 1ns/1ps
`include "prof_defs.svh"

module prof_report_seq (
   input  logic                                          clk,
   input  logic                                          rst_i,
   input  logic                                          finish_i,
   input  prof_pkg::tile_counts_s [`PROF_NUM_TILES-1:0] counts_i,
   output logic                                          done_o,
   output prof_pkg::report_s                             report_o,
   output logic                                          report_v_o,
   output logic                                          report_done_o
);

   localparam prof_pkg::tile_idx_t LAST_TILE = prof_pkg::tile_idx_t'(`PROF_NUM_TILES - 1);
   localparam prof_pkg::slot_idx_t LAST_SLOT = prof_pkg::slot_idx_t'(`PROF_NUM_SLOTS - 1);

   prof_pkg::seq_state_e state_r;
   prof_pkg::tile_idx_t  tile_r;   // tile major walk position
   prof_pkg::slot_idx_t  slot_r;
   logic                 last_rec;
   logic [4:0]           walk_pos;

   assign last_rec = (tile_r == LAST_TILE) && (slot_r == LAST_SLOT);
   assign walk_pos = {tile_r, slot_r};

   //////////////////////////////////////////////////
   // FSM and walk index
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_r <= prof_pkg::IDLE;
         tile_r  <= '0;
         slot_r  <= '0;
      end else begin
         case (state_r)
            prof_pkg::IDLE: begin
               if (finish_i) begin
                  state_r <= prof_pkg::DUMP;
               end
            end
            prof_pkg::DUMP: begin
               slot_r <= slot_r + 1'b1;   // wraps to 0 after slot 7
               if (slot_r == LAST_SLOT) begin
                  tile_r <= tile_r + 1'b1;
               end
               if (last_rec) begin
                  state_r <= prof_pkg::DONE;
               end
            end
            default: begin
               state_r <= prof_pkg::DONE;   // sticky until reset
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // record output
   //////////////////////////////////////////////////

   // counters are held from the edge that raises done, so the
   // registered walk position picks a settled count every cycle
   assign report_o.tile  = tile_r;
   assign report_o.slot  = slot_r;
   assign report_o.count = counts_i[tile_r].cnt[slot_r];

   assign report_v_o    = (state_r == prof_pkg::DUMP);
   assign report_done_o = (state_r == prof_pkg::DONE);
   assign done_o        = (state_r != prof_pkg::IDLE);   // stops all tiles

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // a finish in IDLE reaches a quiet DONE right after the last record
   a_done_quiet: assert property (
      @(posedge clk) disable iff (rst_i)
      ((state_r == prof_pkg::IDLE) && finish_i) |->
         ##(`PROF_NUM_TILES * `PROF_NUM_SLOTS + 1)
         (report_done_o && !report_v_o && $past(report_v_o))
   ) else $error("prof_report_seq: stream did not end in DONE after the last record");

   // walk returns to zero only on the step into DONE
   a_wrap_at_done: assert property (
      @(posedge clk) disable iff (rst_i)
      (walk_pos != '0) ##1 (walk_pos == '0) |->
         (state_r == prof_pkg::DONE) && ($past(state_r) == prof_pkg::DUMP)
   ) else $error("prof_report_seq: walk index wrapped early");

endmodule

//--- src/tile_profiler.sv
`timescale 1ns/1ps
`include "prof_defs.svh"

module tile_profiler (
   input  logic                    clk,
   input  logic                    rst_i,
   input  logic                    freeze_i,
   input  prof_pkg::prof_trigger_s trig_i,
   input  logic                    done_i,
   output prof_pkg::tile_counts_s  counts_o
);

   logic freeze_r;   // freeze level one cycle late
   logic armed_r;    // set by the first unfreeze
   logic unfreeze;
   logic clear;
   logic active;

   logic [`PROF_NUM_EVENTS-1:0] ev;   // events in slot order
   logic [`PROF_NUM_SLOTS-1:0]  hit;

   prof_pkg::cnt_t [`PROF_NUM_SLOTS-1:0] cnt_r;
   prof_pkg::cnt_t [`PROF_NUM_SLOTS-1:0] cnt_nxt;

   //////////////////////////////////////////////////
   // unfreeze detection
   //////////////////////////////////////////////////

   assign unfreeze = freeze_r & ~freeze_i;
   assign clear    = unfreeze & ~done_i;   // a done tile keeps its counts

   // the unfreeze cycle itself is not counted
   assign active = armed_r & ~freeze_i & ~unfreeze & ~done_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         freeze_r <= 1'b0;
         armed_r  <= 1'b0;
      end else begin
         freeze_r <= freeze_i;
         if (unfreeze) begin
            armed_r <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // event strobes to slots
   //////////////////////////////////////////////////

   assign ev[0] = trig_i.dmem_stall;
   assign ev[1] = trig_i.dx_stall;
   assign ev[2] = trig_i.bt_stall;
   assign ev[3] = trig_i.in_fifo_full;
   assign ev[4] = trig_i.out_fifo_full;
   assign ev[5] = trig_i.credit_full;
   assign ev[6] = trig_i.res_acq_stall;

   assign hit = {1'b1, ev};   // top slot counts every active cycle

   // saturating increment that stops at all ones
   always_comb begin
      for (int s = 0; s < `PROF_NUM_SLOTS; s++) begin
         cnt_nxt[s] = cnt_r[s];
         if (hit[s] && (cnt_r[s] != '1)) begin
            cnt_nxt[s] = cnt_r[s] + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // counter bank
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst_i) begin
         cnt_r <= '0;
      end else if (clear) begin
         cnt_r <= '0;
      end else if (active) begin
         cnt_r <= cnt_nxt;
      end
      // frozen or done tiles hold
   end

   assign counts_o.cnt = cnt_r;

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // only an unfreeze clear may bring a count down
   for (genvar g = 0; g < `PROF_NUM_SLOTS; g++) begin : g_chk
      a_no_decrease: assert property (
         @(posedge clk) disable iff (rst_i)
         !clear |=> (cnt_r[g] >= $past(cnt_r[g]))
      ) else $error("tile_profiler: slot %0d count went down", g);
   end

   // done from the sequencer freezes the whole bank
   a_hold_when_done: assert property (
      @(posedge clk) disable iff (rst_i)
      done_i |=> $stable(cnt_r)
   ) else $error("tile_profiler: counts changed while done");

endmodule

//--- tb.f
+incdir+src
src/prof_pkg.sv
src/tile_profiler.sv
src/prof_report_seq.sv
src/manycore_profiler_top.sv
sim/tb_manycore_profiler.sv
